/* common/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// width of the cpu address and data words
`define UART_BUS_BITS 32

// top address bits compared by the peripheral decoder
`define UART_AWIDTH 8

// decoded value of those top bits
`define UART_ADDR 8'h40

// clock cycles per serial bit
`define UART_BAUD_DIVIDE 16

// data bits per character
`define UART_DATA_BITS 8

// start bit, data bits and one stop bit
`define UART_FRAME_BITS 10

`endif

/* common/uart_pkg.sv */
`include "uart_consts.svh"

package uart_pkg;

    // cpu data bus, wishbone style
    typedef logic [`UART_BUS_BITS-1:0]   wb_adr_t;
    typedef logic [`UART_BUS_BITS-1:0]   wb_dat_t;
    typedef logic [`UART_BUS_BITS/8-1:0] wb_sel_t; // one strobe per byte lane

    // one character on the serial line
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // serializer shift register, lsb goes out first
    // layout is {stop, data[7:0], start}
    typedef logic [`UART_FRAME_BITS-1:0] uart_frame_t;

endpackage

/* logic/chip_select.sv */
`timescale 1ns/1ps

module chip_select #(
    parameter int               WIDTH = 8,
    parameter logic [WIDTH-1:0] ADDR  = '0
) (
    input  logic             ck,
    input  logic             rst,
    input  logic [WIDTH-1:0] addr,
    input  logic             wb_cyc,
    output logic             cyc,
    output logic             ack
);

    logic ack_q; // selected on the previous cycle

    // slave is addressed for as long as the master holds the cycle
    assign cyc = wb_cyc & (addr == ADDR);

    always_ff @(posedge ck) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= cyc;
        end
    end

    // drop together with cyc so a finished cycle never sees a stale ack
    assign ack = ack_q & cyc;

endmodule

/* uart/uart_baud.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_baud #(
    parameter int DIVIDE = `UART_BAUD_DIVIDE
) (
    input  logic ck,
    input  logic rst,
    output logic baud_ck
);

    // a divide of 1 still needs a one bit counter
    localparam int CNT_W = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIVIDE - 1);

    logic [CNT_W-1:0] cnt; // cycles since the last strobe

    always_ff @(posedge ck) begin
        if (rst) begin
            cnt     <= '0;
            baud_ck <= 1'b0;
        end else if (cnt == LAST) begin
            cnt     <= '0;
            baud_ck <= 1'b1; // wrap, one cycle strobe
        end else begin
            cnt     <= cnt + 1'b1;
            baud_ck <= 1'b0;
        end
    end

    // strobes are isolated pulses unless every cycle is a bit time
    a_baud_single: assert property (
        @(posedge ck) disable iff (rst)
        (DIVIDE > 1) && baud_ck |=> !baud_ck
    ) else $error("baud_ck high on two consecutive cycles");

    // the next strobe comes a full bit time later
    a_baud_period: assert property (
        @(posedge ck) disable iff (rst)
        (DIVIDE > 1) && baud_ck |-> ##DIVIDE baud_ck
    ) else $error("baud_ck period differs from DIVIDE");

endmodule

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic       ck,
    input  logic       rst,
    input  logic       baud_ck,
    input  uart_byte_t data,
    input  logic       we,
    output logic       ready,
    output logic       tx
);

    localparam int FRAME_W = $bits(uart_frame_t);
    localparam int CNT_W   = $clog2(`UART_FRAME_BITS);

    uart_frame_t      shift; // bits still to go out
    logic [CNT_W-1:0] count; // strobes left before the stop bit shows
    logic             load;

    assign load = we & ready;

    always_ff @(posedge ck) begin
        if (rst) begin
            shift <= '1;
            count <= '0;
            ready <= 1'b1;
            tx    <= 1'b1; // line idles high
        end else begin
            if (baud_ck) begin
                shift <= {1'b1, shift[FRAME_W-1:1]}; // refill with idle ones
                tx    <= shift[0];
                if (count != '0) begin
                    count <= count - 1'b1;
                end
                // true on the strobe that puts the stop bit on the line
                ready <= (count == '0);
            end

            // a load wins over a strobe in the same cycle
            if (load) begin
                shift <= {1'b1, data, 1'b0}; // stop, data, start
                count <= CNT_W'(`UART_FRAME_BITS - 1);
                ready <= 1'b0;
            end
        end
    end

    // an idle serializer with nothing to send keeps the line high
    a_tx_idle_high: assert property (
        @(posedge ck) disable iff (rst)
        ready && !we |=> ready && tx
    ) else $error("tx low or ready lost while idle, tx=%h", tx);

    // ready only drops because a character was taken
    a_tx_load_only: assert property (
        @(posedge ck) disable iff (rst)
        $fell(ready) |-> $past(we)
    ) else $error("ready fell without a write strobe");

endmodule

/* uart/uart_periph.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_periph
    import uart_pkg::*;
#(
    parameter logic [`UART_AWIDTH-1:0] ADDR = `UART_ADDR
) (
    input  logic    ck,
    input  logic    rst,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat,
    input  wb_sel_t wb_sel, // byte lanes not decoded
    input  logic    wb_we,
    input  logic    wb_cyc,
    input  logic    baud_ck,
    output wb_dat_t rdt,
    output logic    ack,
    output logic    tx,
    output logic    busy
);

    localparam int ADR_TOP = $bits(wb_adr_t) - 1;

    logic sel_cyc;   // bus cycle addressed to this peripheral
    logic cs_ack;    // registered acknowledge from the decoder
    logic ready;     // serializer can take a character
    logic was_ready; // serializer state seen just before the access

    chip_select #(
        .WIDTH (`UART_AWIDTH),
        .ADDR  (ADDR)
    ) u_cs (
        .ck     (ck),
        .rst    (rst),
        .addr   (wb_adr[ADR_TOP -: `UART_AWIDTH]),
        .wb_cyc (wb_cyc),
        .cyc    (sel_cyc),
        .ack    (cs_ack)
    );

    uart_tx u_tx (
        .ck      (ck),
        .rst     (rst),
        .baud_ck (baud_ck),
        .data    (wb_dat[`UART_DATA_BITS-1:0]),
        .we      (sel_cyc & wb_we),
        .ready   (ready),
        .tx      (tx)
    );

    // track ready between accesses and freeze it once selected,
    // so the acknowledge path is fixed for the whole access
    always_ff @(posedge ck) begin
        if (rst) begin
            was_ready <= 1'b1;
        end else if (!sel_cyc) begin
            was_ready <= ready;
        end
    end

    // idle serializer: normal one cycle ack from the decoder
    // busy serializer: hold off until ready returns, write lands then
    assign ack = sel_cyc & (was_ready ? cs_ack : ready);

    // status word, only ready in bit 0
    assign rdt = (sel_cyc & ~wb_we) ? wb_dat_t'(ready) : '0;

    assign busy = ~ready;

    a_ack_in_cyc: assert property (
        @(posedge ck) disable iff (rst)
        ack |-> wb_cyc
    ) else $error("ack high without wb_cyc, adr=%h", wb_adr);

    // a write acknowledged while the serializer was busy must start a frame
    a_ack_takes_write: assert property (
        @(posedge ck) disable iff (rst)
        ack && wb_we && !was_ready |=> busy
    ) else $error("back-pressured write acknowledged but not taken");

endmodule

/* logic/uart_subsys.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_subsys
    import uart_pkg::*;
#(
    parameter logic [`UART_AWIDTH-1:0] ADDR   = `UART_ADDR,
    parameter int                      DIVIDE = `UART_BAUD_DIVIDE
) (
    input  logic    ck,
    input  logic    rst,
    // cpu data bus
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat,
    input  wb_sel_t wb_sel,
    input  logic    wb_we,
    input  logic    wb_cyc,
    output wb_dat_t rdt,
    output logic    ack,
    // serial line and status
    output logic    tx,
    output logic    busy
);

    logic baud_ck; // one pulse per bit time

    uart_baud #(
        .DIVIDE (DIVIDE)
    ) u_baud (
        .ck      (ck),
        .rst     (rst),
        .baud_ck (baud_ck)
    );

    uart_periph #(
        .ADDR (ADDR)
    ) u_periph (
        .ck      (ck),
        .rst     (rst),
        .wb_adr  (wb_adr),
        .wb_dat  (wb_dat),
        .wb_sel  (wb_sel),
        .wb_we   (wb_we),
        .wb_cyc  (wb_cyc),
        .baud_ck (baud_ck),
        .rdt     (rdt),
        .ack     (ack),
        .tx      (tx),
        .busy    (busy)
    );

endmodule

/* dv/uart_line_model.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module uart_line_model
    import uart_pkg::*;
#(
    parameter int DIVIDE = `UART_BAUD_DIVIDE
) (
    input  logic        ck,
    input  logic        rst,
    input  logic        tx,
    output logic        rx_valid, // one cycle per decoded frame
    output uart_frame_t rx_frame, // line bits as sampled, start bit in bit 0
    output logic        rx_err    // bad start or stop bit
);

    // samples on the falling clock edge, away from the tx updates
    initial begin : decode
        int   idx;
        logic prev; // line level one sample earlier

        rx_valid = 1'b0;
        rx_frame = '1;
        rx_err   = 1'b0;
        prev     = 1'b1;
        forever begin
            @(negedge ck);
            if (!rst && prev === 1'b1 && tx === 1'b0) begin
                repeat (DIVIDE / 2) @(negedge ck); // middle of the start bit
                rx_frame[0] = tx;
                for (idx = 1; idx < `UART_FRAME_BITS; idx++) begin
                    repeat (DIVIDE) @(negedge ck);
                    rx_frame[idx] = tx;
                end
                rx_err = (rx_frame[0] !== 1'b0) ||
                         (rx_frame[`UART_FRAME_BITS-1] !== 1'b1);
                rx_valid = 1'b1;
                @(negedge ck);
                rx_valid = 1'b0;
            end
            prev = tx;
        end
    end

endmodule

/* dv/tb_uart.sv */
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_uart
    import uart_pkg::*;
();

    localparam int      DIVIDE      = `UART_BAUD_DIVIDE;
    localparam int      FRAME_LIMIT = (`UART_FRAME_BITS + 2) * DIVIDE; // a frame and some
    localparam int      LOW_BITS    = $bits(wb_adr_t) - `UART_AWIDTH;
    localparam wb_adr_t UART_BASE   = {`UART_ADDR, {LOW_BITS{1'b0}}};

    typedef struct packed {
        logic        err;
        uart_frame_t frame;
    } rx_entry_t;

    logic        ck;
    logic        rst;
    wb_adr_t     wb_adr;
    wb_dat_t     wb_dat;
    wb_sel_t     wb_sel;
    logic        wb_we;
    logic        wb_cyc;
    wb_dat_t     rdt;
    logic        ack;
    logic        tx;
    logic        busy;
    logic        rx_valid;
    uart_frame_t rx_frame;
    logic        rx_err;

    uart_byte_t exp_q[$]; // bytes accepted by the DUT, oldest first
    rx_entry_t  rx_q[$];  // frames seen on the line
    int         errors         = 0;
    int         frames_checked = 0;
    int         tests_run      = 0;
    int         tests_failed   = 0;

    uart_subsys DUT (
        .ck     (ck),
        .rst    (rst),
        .wb_adr (wb_adr),
        .wb_dat (wb_dat),
        .wb_sel (wb_sel),
        .wb_we  (wb_we),
        .wb_cyc (wb_cyc),
        .rdt    (rdt),
        .ack    (ack),
        .tx     (tx),
        .busy   (busy)
    );

    uart_line_model #(
        .DIVIDE (DIVIDE)
    ) u_line (
        .ck       (ck),
        .rst      (rst),
        .tx       (tx),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame),
        .rx_err   (rx_err)
    );

    initial begin
        ck = 1'b0;
        forever #20 ck = ~ck;
    end

    // expected line frame for one character
    function automatic uart_frame_t ref_frame(input uart_byte_t b);
        return {1'b1, b, 1'b0}; // stop, data lsb first, start
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            $display("Fail %s: got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    // one bus access, holds cyc until ack or the limit runs out
    task automatic bus_access(input wb_adr_t adr, input wb_dat_t dat, input logic we,
                              input int limit, output logic got_ack, output wb_dat_t rdata,
                              output logic busy_first, output logic busy_ack,
                              output int waited);
        got_ack  = 1'b0;
        rdata    = '0;
        busy_ack = 1'b0;
        waited   = 0;
        @(posedge ck);
        wb_adr <= adr;
        wb_dat <= dat;
        wb_sel <= wb_sel_t'($urandom); // lanes are not decoded
        wb_we  <= we;
        wb_cyc <= 1'b1;
        while (!got_ack && waited < limit) begin
            @(negedge ck);
            waited++;
            if (waited == 1) busy_first = busy;
            if (ack === 1'b1) begin
                got_ack  = 1'b1;
                rdata    = rdt;
                busy_ack = busy;
            end
        end
        @(posedge ck);
        wb_cyc <= 1'b0; // cycle after ack
        wb_we  <= 1'b0;
    endtask

    task automatic wait_frames(input int target, input int limit);
        int n;
        n = 0;
        while (frames_checked < target && n < limit) begin
            @(posedge ck);
            n++;
        end
        expect_true(frames_checked >= target, "timed out waiting for a frame on tx");
    endtask

    task automatic wait_not_busy(input int limit, output int waited);
        waited = 0;
        @(negedge ck);
        while (busy !== 1'b0 && waited < limit) begin
            @(negedge ck);
            waited++;
        end
        expect_true(busy === 1'b0, "timed out waiting for busy to fall");
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run++;
        if (errors == errs_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d error(s)", tests_run, name, errors - errs_at_start);
        end
    endtask

    always @(posedge ck) begin
        if (rx_valid) rx_q.push_back({rx_err, rx_frame});
    end

    // checks each decoded frame against the next accepted byte
    initial begin : compare_frames
        rx_entry_t  got;
        uart_byte_t want;
        forever begin
            @(negedge ck);
            while (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                expect_true(exp_q.size() > 0, "frame on tx with no byte written");
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    expect_value("rx_frame", got.frame, ref_frame(want));
                    expect_value("rx_err", got.err, 1'b0);
                end
                frames_checked++;
            end
        end
    end

    initial begin : main
        int unsigned seed;
        int          start_errs;
        int          sent;
        int          waited;
        logic        got_ack;
        logic        busy_first;
        logic        busy_ack;
        wb_dat_t     rdata;
        uart_byte_t  b;

        seed = 32'h81c7;
        void'($urandom(seed));
        sent   = 0;
        rst    = 1'b1;
        wb_adr = '0;
        wb_dat = '0;
        wb_sel = '0;
        wb_we  = 1'b0;
        wb_cyc = 1'b0;
        repeat (4) @(posedge ck);
        rst <= 1'b0;

        start_errs = errors;
        repeat (40) begin
            @(negedge ck);
            expect_value("tx", tx, 1'b1);
            expect_value("busy", busy, 1'b0);
            expect_value("ack", ack, 1'b0);
        end
        end_test("idle after reset", start_errs);

        start_errs = errors;
        b = 8'ha5;
        bus_access(UART_BASE, wb_dat_t'(b), 1'b1, FRAME_LIMIT, got_ack, rdata, busy_first,
                   busy_ack, waited);
        expect_true(got_ack, "single write was not acknowledged");
        expect_value("busy", busy_ack, 1'b1);
        if (got_ack) begin
            exp_q.push_back(b);
            sent++;
        end
        wait_not_busy(FRAME_LIMIT, waited);
        expect_value("tx", tx, 1'b1); // stop bit on the line
        @(posedge ck);
        expect_true(frames_checked < sent, "busy still high after the stop bit");
        wait_frames(sent, FRAME_LIMIT);
        end_test("single write", start_errs);

        start_errs = errors;
        bus_access(UART_BASE, 32'h3c, 1'b1, FRAME_LIMIT, got_ack, rdata, busy_first,
                   busy_ack, waited);
        expect_true(got_ack, "first of two writes was not acknowledged");
        if (got_ack) begin
            exp_q.push_back(8'h3c);
            sent++;
        end
        bus_access(UART_BASE, 32'hc3, 1'b1, FRAME_LIMIT, got_ack, rdata, busy_first,
                   busy_ack, waited);
        expect_true(got_ack, "second write was never acknowledged");
        expect_true(busy_first && waited > 1, "second write saw no back-pressure");
        expect_value("busy", busy_ack, 1'b0);
        if (got_ack) begin
            exp_q.push_back(8'hc3);
            sent++;
        end
        wait_frames(sent, 2 * FRAME_LIMIT);
        wait_not_busy(FRAME_LIMIT, waited);
        end_test("back-to-back writes", start_errs);

        start_errs = errors;
        bus_access(UART_BASE ^ {8'h01, {LOW_BITS{1'b0}}}, 32'h5a, 1'b1, 4 * DIVIDE,
                   got_ack, rdata, busy_first, busy_ack, waited);
        expect_true(!got_ack, "write to a foreign address was acknowledged");
        repeat (2 * DIVIDE) begin
            @(negedge ck);
            expect_value("tx", tx, 1'b1);
            expect_value("busy", busy, 1'b0);
        end
        end_test("foreign address", start_errs);

        start_errs = errors;
        bus_access(UART_BASE, '0, 1'b0, FRAME_LIMIT, got_ack, rdata, busy_first,
                   busy_ack, waited);
        expect_true(got_ack, "idle status read was not acknowledged");
        expect_value("busy", busy_ack, 1'b0);
        expect_value("rdt", rdata, 32'h1); // ready flag only
        bus_access(UART_BASE, 32'h81, 1'b1, FRAME_LIMIT, got_ack, rdata, busy_first,
                   busy_ack, waited);
        expect_true(got_ack, "write before the busy read was not acknowledged");
        if (got_ack) begin
            exp_q.push_back(8'h81);
            sent++;
        end
        bus_access(UART_BASE, '0, 1'b0, FRAME_LIMIT, got_ack, rdata, busy_first,
                   busy_ack, waited);
        expect_true(got_ack, "status read during a frame was never acknowledged");
        expect_true(busy_first, "status read did not find the transmitter busy");
        expect_value("busy", busy_ack, 1'b0); // ack only once ready is back
        expect_value("rdt", rdata, 32'h1);
        wait_frames(sent, FRAME_LIMIT);
        wait_not_busy(FRAME_LIMIT, waited);
        end_test("status read", start_errs);

        start_errs = errors;
        for (int i = 0; i < 20; i++) begin
            b = uart_byte_t'($urandom);
            bus_access({`UART_ADDR, LOW_BITS'($urandom)}, wb_dat_t'($urandom) << 8 | b,
                       1'b1, FRAME_LIMIT, got_ack, rdata, busy_first, busy_ack, waited);
            expect_true(got_ack, "random write was not acknowledged");
            if (got_ack) begin
                exp_q.push_back(b);
                sent++;
            end
        end
        wait_frames(sent, 2 * FRAME_LIMIT);
        repeat (DIVIDE) @(posedge ck); // let the last stop bit finish
        expect_value("exp_q.size", exp_q.size(), 0);
        expect_value("frames_checked", frames_checked, sent);
        end_test("random bytes", start_errs);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/uart_pkg.sv
logic/chip_select.sv
uart/uart_baud.sv
uart/uart_tx.sv
uart/uart_periph.sv
logic/uart_subsys.sv
dv/uart_line_model.sv
dv/tb_uart.sv

/* Bender.yml */
package:
  name: uart_subsys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/uart_pkg.sv
      - logic/chip_select.sv
      - uart/uart_baud.sv
      - uart/uart_tx.sv
      - uart/uart_periph.sv
      - logic/uart_subsys.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/uart_line_model.sv
      - dv/tb_uart.sv
